//--- common/xm_regs_pkg.sv
//======================================================================
// host register side shared definitions
// bus byte, data word and VRAM address types
// register number enum for the host register map
//======================================================================
`default_nettype none

package xm_regs_pkg;

localparam int BYTE_W = 8;                  // host bus byte
localparam int WORD_W = 16;                 // register / VRAM word
localparam int ADDR_W = 16;                 // VRAM word address

typedef logic [BYTE_W-1:0] byte_t;          // one bus data byte
typedef logic [WORD_W-1:0] word_t;          // register or VRAM data word
typedef logic [ADDR_W-1:0] addr_t;          // VRAM word address

// register numbers; anything not listed reads zero, ignores writes
typedef enum logic [3:0] {
    XM_SYS_CTRL = 4'h0,                     // busy bit, nibble write mask
    XM_TIMER    = 4'h2,                     // tenth-ms tick count
    XM_RD_INCR  = 4'h6,                     // read address step
    XM_RD_ADDR  = 4'h7,                     // odd byte write starts a read
    XM_WR_INCR  = 4'h8,                     // write address step
    XM_WR_ADDR  = 4'h9,                     // VRAM write address
    XM_DATA     = 4'hA                      // odd write = VRAM write, odd read = pre-read
} reg_num_t;

endpackage

`default_nettype wire

//--- common/xm_access_pkg.sv
//======================================================================
// VRAM access side shared definitions
// access FSM states, nibble write mask type, reset values
//======================================================================
`default_nettype none

package xm_access_pkg;

typedef enum logic [1:0] {
    IDLE,                                   // no VRAM access presented
    RD_WAIT,                                // read presented, awaiting ack
    WR_WAIT                                 // write presented, awaiting ack
} acc_state_t;

typedef logic [3:0] wrmask_t;               // one enable per data nibble

localparam wrmask_t WRMASK_RESET = 4'hF;    // all nibbles writable

endpackage

`default_nettype wire

//--- rtl/access_ctrl.sv
//======================================================================
// VRAM access control
// command decode from bus strobes, access FSM, sel/ack handshake,
// step and capture pulses, nibble write mask register
//======================================================================
`default_nettype none
`timescale 1ns/100ps

module access_ctrl (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_wr_i,
    input  wire logic                   bus_rd_i,
    input  wire xm_regs_pkg::reg_num_t  bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,
    input  wire xm_regs_pkg::byte_t     bus_data_i,
    input  wire xm_regs_pkg::addr_t     rd_addr_i,
    input  wire xm_regs_pkg::addr_t     wr_addr_i,
    input  wire xm_regs_pkg::word_t     wr_word_i,      // word to write on DATA odd byte
    input  wire logic                   vram_ack_i,
    output      logic                   vram_sel_o,
    output      logic                   vram_wr_o,
    output      xm_regs_pkg::addr_t     vram_addr_o,
    output      xm_regs_pkg::word_t     vram_data_o,
    output      xm_access_pkg::wrmask_t vram_wrmask_o,
    output      logic                   rd_step_o,
    output      logic                   wr_step_o,
    output      logic                   rd_capture_o,
    output      logic                   busy_o
);

import xm_regs_pkg::*;
import xm_access_pkg::*;

acc_state_t state;
logic       odd_wr;                     // odd byte write this cycle
logic       wr_cmd;                     // DATA odd write
logic       rdaddr_cmd;                 // RD_ADDR odd write
logic       rddata_cmd;                 // DATA odd read, pre-read next word

assign odd_wr     = bus_wr_i && bus_bytesel_i;
assign wr_cmd     = odd_wr && (bus_reg_num_i == XM_DATA);
assign rdaddr_cmd = odd_wr && (bus_reg_num_i == XM_RD_ADDR);
assign rddata_cmd = bus_rd_i && bus_bytesel_i && (bus_reg_num_i == XM_DATA);

assign vram_sel_o   = (state != IDLE);          // straight from state flops
assign vram_wr_o    = (state == WR_WAIT);
assign busy_o       = vram_sel_o;
assign rd_step_o    = vram_ack_i && (state == RD_WAIT);
assign rd_capture_o = rd_step_o;                // data valid in ack cycle
assign wr_step_o    = vram_ack_i && (state == WR_WAIT);

always_ff @(posedge clk) begin
    if (reset_i) begin
        state <= IDLE;
    end else begin
        case (state)
            IDLE: begin
                if (wr_cmd) begin
                    state <= WR_WAIT;
                end else if (rdaddr_cmd || rddata_cmd) begin
                    state <= RD_WAIT;
                end
            end
            RD_WAIT, WR_WAIT: begin
                if (vram_ack_i) state <= IDLE;      // drop sel next cycle
            end
            default: state <= IDLE;
        endcase
    end
end

// payload only loads when idle, so it holds through the whole access
always_ff @(posedge clk) begin
    if (state == IDLE) begin
        if (wr_cmd) begin
            vram_addr_o <= wr_addr_i;
            vram_data_o <= wr_word_i;
        end else if (rdaddr_cmd) begin
            vram_addr_o <= {rd_addr_i[15:8], bus_data_i};   // new RD_ADDR
        end else if (rddata_cmd) begin
            vram_addr_o <= rd_addr_i;                       // already stepped
        end
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        vram_wrmask_o <= WRMASK_RESET;
    end else if (odd_wr && (bus_reg_num_i == XM_SYS_CTRL)) begin
        vram_wrmask_o <= bus_data_i[3:0];
    end
end

a_ack_has_sel: assert property (@(posedge clk) disable iff (reset_i)
    vram_ack_i |-> vram_sel_o);
a_payload_stable: assert property (@(posedge clk) disable iff (reset_i)
    vram_sel_o && !vram_ack_i |=> $stable(vram_addr_o) && $stable(vram_data_o));

endmodule

`default_nettype wire

//--- rtl/addr_regs.sv
//======================================================================
// VRAM address and increment registers
// RD_INCR, RD_ADDR, WR_INCR, WR_ADDR with byte writes,
// post-access increment on step pulses
//======================================================================
`default_nettype none
`timescale 1ns/100ps

module addr_regs (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_wr_i,
    input  wire xm_regs_pkg::reg_num_t  bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,
    input  wire xm_regs_pkg::byte_t     bus_data_i,
    input  wire logic                   rd_step_i,      // read acked
    input  wire logic                   wr_step_i,      // write acked
    output      xm_regs_pkg::addr_t     rd_addr_o,
    output      xm_regs_pkg::addr_t     wr_addr_o,
    output      xm_regs_pkg::word_t     rd_incr_o,
    output      xm_regs_pkg::word_t     wr_incr_o
);

import xm_regs_pkg::*;

logic rd_incr_wr;
logic rd_addr_wr;
logic wr_incr_wr;
logic wr_addr_wr;

// replace one byte of a register, odd = low byte
function automatic word_t put_byte(word_t old_word, logic odd, byte_t new_byte);
    return odd ? {old_word[15:8], new_byte} : {new_byte, old_word[7:0]};
endfunction

assign rd_incr_wr = bus_wr_i && (bus_reg_num_i == XM_RD_INCR);
assign rd_addr_wr = bus_wr_i && (bus_reg_num_i == XM_RD_ADDR);
assign wr_incr_wr = bus_wr_i && (bus_reg_num_i == XM_WR_INCR);
assign wr_addr_wr = bus_wr_i && (bus_reg_num_i == XM_WR_ADDR);

always_ff @(posedge clk) begin
    if (reset_i) begin
        rd_incr_o <= '0;
        rd_addr_o <= '0;
        wr_incr_o <= '0;
        wr_addr_o <= '0;
    end else begin
        if (rd_incr_wr) rd_incr_o <= put_byte(rd_incr_o, bus_bytesel_i, bus_data_i);
        if (wr_incr_wr) wr_incr_o <= put_byte(wr_incr_o, bus_bytesel_i, bus_data_i);

        if (rd_addr_wr) begin                   // host write beats step
            rd_addr_o <= put_byte(rd_addr_o, bus_bytesel_i, bus_data_i);
        end else if (rd_step_i) begin
            rd_addr_o <= rd_addr_o + rd_incr_o; // wraps mod 2^16
        end

        if (wr_addr_wr) begin
            wr_addr_o <= put_byte(wr_addr_o, bus_bytesel_i, bus_data_i);
        end else if (wr_step_i) begin
            wr_addr_o <= wr_addr_o + wr_incr_o;
        end
    end
end

endmodule

`default_nettype wire

//--- rtl/data_latch.sv
//======================================================================
// DATA register storage and host read-back
// even byte hold, VRAM read word capture, register read mux
//======================================================================
`default_nettype none
`timescale 1ns/100ps

module data_latch (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_wr_i,
    input  wire xm_regs_pkg::reg_num_t  bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,
    input  wire xm_regs_pkg::byte_t     bus_data_i,
    input  wire logic                   rd_capture_i,   // VRAM read acked
    input  wire xm_regs_pkg::word_t     vram_data_i,
    input  wire logic                   busy_i,
    input  wire xm_access_pkg::wrmask_t wrmask_i,
    input  wire xm_regs_pkg::addr_t     rd_addr_i,
    input  wire xm_regs_pkg::addr_t     wr_addr_i,
    input  wire xm_regs_pkg::word_t     rd_incr_i,
    input  wire xm_regs_pkg::word_t     wr_incr_i,
    input  wire xm_regs_pkg::word_t     timer_word_i,
    output      xm_regs_pkg::word_t     wr_word_o,
    output      xm_regs_pkg::byte_t     bus_data_o
);

import xm_regs_pkg::*;

byte_t  data_even;                      // DATA even byte, waits for odd
word_t  rd_word;                        // last word read from VRAM
word_t  rb_word;                        // word picked by register number

assign wr_word_o = {data_even, bus_data_i};     // odd byte straight off bus

always_ff @(posedge clk) begin
    if (reset_i) begin
        data_even <= '0;
        rd_word   <= '0;
    end else begin
        if (bus_wr_i && !bus_bytesel_i && (bus_reg_num_i == XM_DATA)) begin
            data_even <= bus_data_i;
        end
        if (rd_capture_i) rd_word <= vram_data_i;
    end
end

always_comb begin
    case (bus_reg_num_i)
        XM_SYS_CTRL: rb_word = {busy_i, 11'b0, wrmask_i};   // busy in bit 15
        XM_TIMER:    rb_word = timer_word_i;
        XM_RD_INCR:  rb_word = rd_incr_i;
        XM_RD_ADDR:  rb_word = rd_addr_i;
        XM_WR_INCR:  rb_word = wr_incr_i;
        XM_WR_ADDR:  rb_word = wr_addr_i;
        XM_DATA:     rb_word = rd_word;
        default:     rb_word = '0;                          // unmapped reads zero
    endcase
end

assign bus_data_o = bus_bytesel_i ? rb_word[7:0] : rb_word[15:8];

endmodule

`default_nettype wire

//--- rtl/tenth_ms_timer.sv
//======================================================================
// tenth-millisecond timer
// clock prescaler, 16-bit tick count, low byte latch on TIMER read
//======================================================================
`default_nettype none
`timescale 1ns/100ps

module tenth_ms_timer #(
    parameter int CLKS_PER_TICK = 2500                  // clocks per 0.1 ms
) (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_rd_i,
    input  wire xm_regs_pkg::reg_num_t  bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,
    output      xm_regs_pkg::word_t     timer_word_o    // live high, latched low
);

import xm_regs_pkg::*;

localparam int PRE_W = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;

logic [PRE_W-1:0]   prescale;           // clocks into current tick
word_t              ticks;              // free-running tick count
byte_t              low_latch;          // low byte frozen on even read

assign timer_word_o = {ticks[15:8], low_latch};

always_ff @(posedge clk) begin
    if (reset_i) begin
        prescale  <= '0;
        ticks     <= '0;
        low_latch <= '0;
    end else begin
        if (prescale == PRE_W'(CLKS_PER_TICK - 1)) begin
            prescale <= '0;
            ticks    <= ticks + 1'b1;
        end else begin
            prescale <= prescale + 1'b1;
        end
        // even byte read, so the odd read that follows is coherent
        if (bus_rd_i && !bus_bytesel_i && (bus_reg_num_i == XM_TIMER)) begin
            low_latch <= ticks[7:0];
        end
    end
end

a_prescale_range: assert property (@(posedge clk) disable iff (reset_i)
    prescale < CLKS_PER_TICK);

endmodule

`default_nettype wire

//--- rtl/xm_regs_top.sv
//======================================================================
// host register block top level
// access control FSM, address registers, data latch, timer
//======================================================================
`default_nettype none
`timescale 1ns/100ps

module xm_regs_top #(
    parameter int CLKS_PER_TICK = 2500                  // 25 MHz / 10 kHz
) (
    input  wire logic                   clk,
    input  wire logic                   reset_i,
    input  wire logic                   bus_wr_i,       // byte write strobe
    input  wire logic                   bus_rd_i,       // byte read strobe
    input  wire xm_regs_pkg::reg_num_t  bus_reg_num_i,
    input  wire logic                   bus_bytesel_i,  // 0 = even/high, 1 = odd/low
    input  wire xm_regs_pkg::byte_t     bus_data_i,
    output      xm_regs_pkg::byte_t     bus_data_o,     // read-back byte
    output      logic                   vram_sel_o,
    output      logic                   vram_wr_o,
    output      xm_regs_pkg::addr_t     vram_addr_o,
    output      xm_regs_pkg::word_t     vram_data_o,
    output      xm_access_pkg::wrmask_t vram_wrmask_o,
    input  wire logic                   vram_ack_i,
    input  wire xm_regs_pkg::word_t     vram_data_i
);

import xm_regs_pkg::*;

addr_t      rd_addr;                    // RD_ADDR contents
addr_t      wr_addr;                    // WR_ADDR contents
word_t      rd_incr;
word_t      wr_incr;
word_t      wr_word;                    // even byte + odd bus byte
word_t      timer_word;                 // live high, latched low
logic       rd_step;                    // read done, bump RD_ADDR
logic       wr_step;                    // write done, bump WR_ADDR
logic       rd_capture;                 // take vram_data_i
logic       busy;

access_ctrl access_ctrl_i (
    .clk(clk),
    .reset_i(reset_i),
    .bus_wr_i(bus_wr_i),
    .bus_rd_i(bus_rd_i),
    .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),
    .rd_addr_i(rd_addr),
    .wr_addr_i(wr_addr),
    .wr_word_i(wr_word),
    .vram_ack_i(vram_ack_i),
    .vram_sel_o(vram_sel_o),
    .vram_wr_o(vram_wr_o),
    .vram_addr_o(vram_addr_o),
    .vram_data_o(vram_data_o),
    .vram_wrmask_o(vram_wrmask_o),
    .rd_step_o(rd_step),
    .wr_step_o(wr_step),
    .rd_capture_o(rd_capture),
    .busy_o(busy)
);

addr_regs addr_regs_i (
    .clk(clk),
    .reset_i(reset_i),
    .bus_wr_i(bus_wr_i),
    .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),
    .rd_step_i(rd_step),
    .wr_step_i(wr_step),
    .rd_addr_o(rd_addr),
    .wr_addr_o(wr_addr),
    .rd_incr_o(rd_incr),
    .wr_incr_o(wr_incr)
);

data_latch data_latch_i (
    .clk(clk),
    .reset_i(reset_i),
    .bus_wr_i(bus_wr_i),
    .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i),
    .bus_data_i(bus_data_i),
    .rd_capture_i(rd_capture),
    .vram_data_i(vram_data_i),
    .busy_i(busy),
    .wrmask_i(vram_wrmask_o),
    .rd_addr_i(rd_addr),
    .wr_addr_i(wr_addr),
    .rd_incr_i(rd_incr),
    .wr_incr_i(wr_incr),
    .timer_word_i(timer_word),
    .wr_word_o(wr_word),
    .bus_data_o(bus_data_o)
);

tenth_ms_timer #(
    .CLKS_PER_TICK(CLKS_PER_TICK)
) tenth_ms_timer_i (
    .clk(clk),
    .reset_i(reset_i),
    .bus_rd_i(bus_rd_i),
    .bus_reg_num_i(bus_reg_num_i),
    .bus_bytesel_i(bus_bytesel_i),
    .timer_word_o(timer_word)
);

endmodule

`default_nettype wire

//--- tb/tb_xm_regs.sv
//======================================================================
// testbench for the host register block
// clock, reset, DUT, VRAM model with random ack delay, xorshift,
// compare tasks, directed tests for registers, VRAM access, timer
//======================================================================
`default_nettype none
`timescale 1ns/100ps

module tb_xm_regs;

import xm_regs_pkg::*;
import xm_access_pkg::*;

localparam int CLKS         = 8;            // timer prescale for fast ticks
localparam int IDLE_TIMEOUT = 100;          // busy polls before giving up

logic       clk;
logic       reset_i;
logic       bus_wr_i;
logic       bus_rd_i;
reg_num_t   bus_reg_num_i;
logic       bus_bytesel_i;
byte_t      bus_data_i;
byte_t      bus_data_o;
logic       vram_sel_o;
logic       vram_wr_o;
addr_t      vram_addr_o;
word_t      vram_data_o;
wrmask_t    vram_wrmask_o;
logic       vram_ack_i;
word_t      vram_data_i;

word_t       mem [0:65535];                 // VRAM model contents
logic [31:0] rng_state = 32'hf9af_3c74;
int          checks;
int          errors;
int          tests;
int          ack_wait;                      // cycles left before ack
logic        ack_pending;

xm_regs_top #(
    .CLKS_PER_TICK(CLKS)
) xm_regs_top_i (.*);

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;                 // 20 ns period
end

function automatic logic [31:0] next_rand();
    logic [31:0] s;
    s = rng_state;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    rng_state = s;
    return s;
endfunction

// byte swap plus constant, every address bit matters
function automatic word_t fill_word(addr_t a);
    return {a[7:0], a[15:8]} ^ 16'h5ac3;
endfunction

function automatic word_t nibble_bits(wrmask_t m);
    return {{4{m[3]}}, {4{m[2]}}, {4{m[1]}}, {4{m[0]}}};
endfunction

// VRAM model, acks 1..4 cycles after sel rises
initial begin
    vram_ack_i  = 1'b0;
    vram_data_i = '0;
    ack_pending = 1'b0;
    ack_wait    = 0;
    forever begin
        @(posedge clk);
        #2;
        vram_ack_i = 1'b0;
        if (vram_sel_o === 1'b1) begin
            if (!ack_pending) begin         // new access presented
                ack_pending = 1'b1;
                ack_wait    = int'(next_rand() % 4);
            end
            if (ack_wait == 0) begin
                ack_pending = 1'b0;
                vram_ack_i  = 1'b1;
                if (vram_wr_o) begin
                    mem[vram_addr_o] = (mem[vram_addr_o] & ~nibble_bits(vram_wrmask_o))
                                     | (vram_data_o & nibble_bits(vram_wrmask_o));
                end else begin
                    vram_data_i = mem[vram_addr_o];
                end
            end else begin
                ack_wait--;
            end
        end
    end
end

task automatic check_byte(string name, byte_t exp, byte_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic check_word(string name, word_t exp, word_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic check_addr(string name, addr_t exp, addr_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic abort_run(string why);
    $display("%s", why);
    $display("TB FAILED");
    $finish;
endtask

// bus tasks start and end 2 ns after a rising edge
task automatic bus_write(reg_num_t num, logic odd, byte_t data);
    bus_wr_i      = 1'b1;
    bus_reg_num_i = num;
    bus_bytesel_i = odd;
    bus_data_i    = data;
    @(posedge clk);
    #2;
    bus_wr_i = 1'b0;
endtask

task automatic bus_read(reg_num_t num, logic odd, output byte_t data);
    bus_rd_i      = 1'b1;
    bus_reg_num_i = num;
    bus_bytesel_i = odd;
    @(negedge clk);
    data = bus_data_o;                      // mux settled mid cycle
    @(posedge clk);
    #2;
    bus_rd_i = 1'b0;
endtask

task automatic write_word(reg_num_t num, word_t w);
    bus_write(num, 1'b0, w[15:8]);          // even byte first
    bus_write(num, 1'b1, w[7:0]);
endtask

task automatic read_word(reg_num_t num, output word_t w);
    byte_t hi;
    byte_t lo;
    bus_read(num, 1'b0, hi);
    bus_read(num, 1'b1, lo);
    w = {hi, lo};
endtask

task automatic wait_idle();
    byte_t status;
    int    polls;
    polls = 0;
    bus_read(XM_SYS_CTRL, 1'b0, status);
    while (status[7] && polls < IDLE_TIMEOUT) begin    // busy in bit 15
        polls++;
        bus_read(XM_SYS_CTRL, 1'b0, status);
    end
    if (status[7]) abort_run("busy bit never cleared, VRAM access did not finish");
endtask

task automatic end_test(string name, int errs_before);
    tests++;
    if (errors == errs_before) $display("test %-12s ok", name);
    else $display("test %-12s %0d errors", name, errors - errs_before);
endtask

task automatic reset_values();
    int    e0;
    word_t w;
    byte_t b;
    e0 = errors;
    check_byte("vram_sel_o", 8'h00, {7'b0, vram_sel_o});
    check_byte("vram_wr_o", 8'h00, {7'b0, vram_wr_o});
    read_word(XM_TIMER, w);                 // first tick is still 8 clocks away
    check_word("timer", 16'h0000, w);
    bus_read(XM_SYS_CTRL, 1'b0, b);
    check_byte("sys_ctrl_hi", 8'h00, b);
    bus_read(XM_SYS_CTRL, 1'b1, b);
    check_byte("sys_ctrl_lo", 8'h0f, b);    // all nibbles enabled
    read_word(XM_RD_INCR, w);
    check_word("rd_incr", 16'h0000, w);
    read_word(XM_RD_ADDR, w);
    check_addr("rd_addr", 16'h0000, w);
    read_word(XM_WR_INCR, w);
    check_word("wr_incr", 16'h0000, w);
    read_word(XM_WR_ADDR, w);
    check_addr("wr_addr", 16'h0000, w);
    read_word(XM_DATA, w);                  // odd read also starts a pre-read
    check_word("data", 16'h0000, w);
    wait_idle();
    end_test("reset", e0);
endtask

task automatic reg_readback();
    int         e0;
    word_t      v;
    word_t      w;
    logic [3:0] unused_nums [9] = '{4'h1, 4'h3, 4'h4, 4'h5, 4'hb, 4'hc, 4'hd, 4'he, 4'hf};
    e0 = errors;
    v = word_t'(next_rand());
    write_word(XM_RD_INCR, v);
    read_word(XM_RD_INCR, w);
    check_word("rd_incr", v, w);
    v = word_t'(next_rand());
    write_word(XM_WR_INCR, v);
    read_word(XM_WR_INCR, w);
    check_word("wr_incr", v, w);
    v = word_t'(next_rand());
    write_word(XM_WR_ADDR, v);
    read_word(XM_WR_ADDR, w);
    check_addr("wr_addr", v, w);
    foreach (unused_nums[i]) begin          // writes ignored, reads zero
        write_word(reg_num_t'(unused_nums[i]), 16'hffff);
        read_word(reg_num_t'(unused_nums[i]), w);
        check_word("unused_reg", 16'h0000, w);
    end
    end_test("readback", e0);
endtask

task automatic write_stream();
    int    e0;
    word_t words [6];
    addr_t base;
    addr_t step;
    word_t w;
    e0   = errors;
    base = 16'h1200;
    step = 16'h0003;
    write_word(XM_WR_INCR, step);
    write_word(XM_WR_ADDR, base);
    foreach (words[i]) begin
        words[i] = word_t'(next_rand());
        write_word(XM_DATA, words[i]);      // odd byte starts the write
        wait_idle();
    end
    foreach (words[i]) check_word("mem", words[i], mem[base + 16'(i) * step]);
    read_word(XM_WR_ADDR, w);
    check_addr("wr_addr", base + 16'(6) * step, w);
    end_test("write_stream", e0);
endtask

task automatic masked_write();
    int    e0;
    addr_t a;
    word_t nw;
    word_t old_w;
    byte_t b;
    e0    = errors;
    a     = 16'h3456;                       // untouched, still fill pattern
    old_w = fill_word(a);
    nw    = word_t'(next_rand());
    bus_write(XM_SYS_CTRL, 1'b1, 8'h03);
    write_word(XM_WR_ADDR, a);
    write_word(XM_DATA, nw);
    wait_idle();
    check_word("mem_masked", {old_w[15:8], nw[7:0]}, mem[a]);
    check_byte("vram_wrmask_o", 8'h03, {4'h0, vram_wrmask_o});
    bus_read(XM_SYS_CTRL, 1'b1, b);
    check_byte("sys_ctrl_lo", 8'h03, b);
    bus_write(XM_SYS_CTRL, 1'b1, 8'h0f);    // back to full words
    end_test("write_mask", e0);
endtask

task automatic read_stream();
    int    e0;
    addr_t base;
    addr_t step;
    word_t w;
    e0   = errors;
    base = 16'h8000;
    step = 16'h0005;
    write_word(XM_RD_INCR, step);
    write_word(XM_RD_ADDR, base);           // odd byte fetches first word
    wait_idle();
    for (int i = 0; i < 6; i++) begin
        read_word(XM_DATA, w);              // odd read fetches the next one
        check_word("data", fill_word(base + 16'(i) * step), w);
        wait_idle();
    end
    read_word(XM_RD_ADDR, w);
    check_addr("rd_addr", base + 16'(7) * step, w);
    end_test("read_stream", e0);
endtask

task automatic timer_count();
    int    e0;
    word_t t0;
    word_t t1;
    word_t diff;
    byte_t hi;
    byte_t lo;
    e0 = errors;
    read_word(XM_TIMER, t0);
    repeat (40 * CLKS) @(posedge clk);
    #2;
    read_word(XM_TIMER, t1);
    diff = t1 - t0;
    checks++;
    if (diff < 16'd39 || diff > 16'd41) begin
        errors++;
        $display("timer advanced %0d ticks in %0d cycles, expected about 40", diff, 40 * CLKS);
    end
    // low byte must come from the even read, 22 cycles before the next even read
    bus_read(XM_TIMER, 1'b0, hi);
    repeat (2 * CLKS + 4) @(posedge clk);
    #2;
    bus_read(XM_TIMER, 1'b1, lo);
    read_word(XM_TIMER, t1);
    diff = t1 - {hi, lo};
    checks++;
    if (diff < 16'd2 || diff > 16'd3) begin
        errors++;
        $display("timer low byte followed the live count between the even and odd reads");
    end
    end_test("timer", e0);
endtask

initial begin
    reset_i       = 1'b1;
    bus_wr_i      = 1'b0;
    bus_rd_i      = 1'b0;
    bus_reg_num_i = XM_SYS_CTRL;
    bus_bytesel_i = 1'b0;
    bus_data_i    = '0;
    checks        = 0;
    errors        = 0;
    tests         = 0;
    for (int a = 0; a < 65536; a++) mem[16'(a)] = fill_word(16'(a));
    repeat (16) @(posedge clk);
    #2;
    reset_i = 1'b0;
    reset_values();
    reg_readback();
    write_stream();
    masked_write();
    read_stream();
    timer_count();
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
        $display("TB PASSED");
    end else begin
        $display("TB FAILED");
    end
    $finish;
end

endmodule

`default_nettype wire

//--- list.f
common/xm_regs_pkg.sv
common/xm_access_pkg.sv
rtl/access_ctrl.sv
rtl/addr_regs.sv
rtl/data_latch.sv
rtl/tenth_ms_timer.sv
rtl/xm_regs_top.sv
tb/tb_xm_regs.sv

//--- run.sh
#!/bin/sh
# compile the testbench with Verilator, run it, decide on the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_xm_regs \
    -f list.f -Mdir obj_dir -o tb_xm_regs_sim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/tb_xm_regs_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
exit 1
